// ==== hdl/qbc_pkg.sv ====
`default_nettype none

package qbc_pkg;

    //////////////////////////////////////////////////
    // Geometry and timing constants
    //////////////////////////////////////////////////

    // Row and column counts, input positions
    localparam int COORD_W = 10;

    // Pixel sequence memory is 4K deep
    localparam int SEQ_ADDR_W = 12;

    // One 3x3 window takes one cycle per tap
    localparam int WINDOW_CYCLES = 9;

    // Sequence BRAM read plus its output registers
    localparam int SEQ_RD_LATENCY = 3;

    // Rows loaded before the first pass can start
    localparam int PRIME_ROWS = 3;

    //////////////////////////////////////////////////
    // Job state, one-hot
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        ST_IDLE          = 6'b000001,
        ST_PRIME         = 6'b000010,
        ST_FETCH_WAIT    = 6'b000100,
        ST_ACTIVE        = 6'b001000,
        ST_WAIT_DONE     = 6'b010000,
        ST_SEND_COMPLETE = 6'b100000
    } seq_state_t;

    //////////////////////////////////////////////////
    // Job geometry and input position
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [COORD_W-1:0] num_rows;
        logic [COORD_W-1:0] num_cols;
        // Windows per pass
        logic [7:0]         seq_windows;
    } job_cfg_t;

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } pos_t;

endpackage

`default_nettype wire

// ==== hdl/job_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module job_sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire qbc_pkg::job_cfg_t cfg,
    input  wire qbc_pkg::pos_t   pos,
    input  wire                  job_start,
    output logic                 job_accept,
    output logic                 fetch_request,
    input  wire                  fetch_ack,
    input  wire                  row_loaded,
    input  wire                  row_drained,
    output logic                 fetch_start,
    output logic                 drain,
    output logic                 pass_start,
    input  wire                  pass_done,
    input  wire                  pipeline_flushed,
    output logic                 job_complete,
    input  wire                  job_complete_ack,
    output logic [1:0]           gray_code,
    output qbc_pkg::seq_state_t  state
);

    // Where FETCH_WAIT goes once the row is in
    qbc_pkg::seq_state_t return_state;
    logic                fetch_acked;
    logic                pass_busy;
    logic [1:0]          pass_cnt;

    // Binary pass count to Gray
    assign gray_code = {pass_cnt[1], pass_cnt[1] ^ pass_cnt[0]};

    //////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= qbc_pkg::ST_IDLE;
            return_state  <= qbc_pkg::ST_PRIME;
            job_accept    <= 1'b0;
            fetch_request <= 1'b0;
            fetch_acked   <= 1'b0;
            fetch_start   <= 1'b0;
            drain         <= 1'b0;
            pass_start    <= 1'b0;
            pass_busy     <= 1'b0;
            pass_cnt      <= 2'b00;
            job_complete  <= 1'b0;
        end else begin
            job_accept  <= 1'b0;
            fetch_start <= 1'b0;
            pass_start  <= 1'b0;

            // Tracker has read out the whole row
            if (row_drained) begin
                drain <= 1'b0;
            end

            case (state)
                qbc_pkg::ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= qbc_pkg::ST_PRIME;
                    end
                end
                qbc_pkg::ST_PRIME: begin
                    // Fill the window rows one at a time
                    if (!drain) begin
                        if (pos.row < qbc_pkg::PRIME_ROWS) begin
                            return_state <= qbc_pkg::ST_PRIME;
                            state        <= qbc_pkg::ST_FETCH_WAIT;
                        end else begin
                            state <= qbc_pkg::ST_ACTIVE;
                        end
                    end
                end
                qbc_pkg::ST_FETCH_WAIT: begin
                    // Request held until ack, never raised twice per row
                    fetch_request <= !fetch_ack && !fetch_acked;
                    fetch_start   <= !fetch_ack && !fetch_acked && !fetch_request;
                    if (fetch_ack) begin
                        fetch_acked <= 1'b1;
                    end
                    if (row_loaded) begin
                        fetch_acked   <= 1'b0;
                        fetch_request <= 1'b0;
                        drain         <= 1'b1;
                        state         <= return_state;
                    end
                end
                qbc_pkg::ST_ACTIVE: begin
                    if (pass_busy) begin
                        if (pass_done) begin
                            pass_busy <= 1'b0;
                            pass_cnt  <= pass_cnt + 2'd1;
                            // Last input row already used
                            if (pos.row >= cfg.num_rows) begin
                                state <= qbc_pkg::ST_WAIT_DONE;
                            end else begin
                                return_state <= qbc_pkg::ST_ACTIVE;
                                state        <= qbc_pkg::ST_FETCH_WAIT;
                            end
                        end
                    end else if (!drain) begin
                        pass_start <= 1'b1;
                        pass_busy  <= 1'b1;
                    end
                end
                qbc_pkg::ST_WAIT_DONE: begin
                    if (pipeline_flushed) begin
                        state <= qbc_pkg::ST_SEND_COMPLETE;
                    end
                end
                qbc_pkg::ST_SEND_COMPLETE: begin
                    job_complete <= !job_complete_ack;
                    if (job_complete_ack) begin
                        pass_cnt <= 2'b00;
                        state    <= qbc_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= qbc_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/row_fetch_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_fetch_tracker (
    input  wire                    clk,
    input  wire                    rst,
    input  wire qbc_pkg::job_cfg_t cfg,
    input  wire                    fetch_start,
    input  wire                    fetch_ack,
    input  wire                    fetch_complete,
    input  wire                    drain,
    input  wire                    job_complete_ack,
    output logic                   pfb_rden,
    output logic                   row_loaded,
    output logic                   row_drained,
    output qbc_pkg::pos_t          pos
);

    logic                        fetch_pending;
    logic                        fetch_in_progress;
    logic [qbc_pkg::COORD_W-1:0] pfb_count;
    logic                        row_end;

    // Complete only counts for a fetch that was acked
    assign row_loaded = fetch_complete && fetch_in_progress;

    // One pixel per cycle while the buffer holds any
    assign pfb_rden = drain && (pfb_count != '0);
    assign row_end  = pfb_rden && (pfb_count == 1);

    //////////////////////////////////////////////////
    // Fetch tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pending     <= 1'b0;
            fetch_in_progress <= 1'b0;
        end else begin
            if (fetch_start) begin
                fetch_pending <= 1'b1;
            end
            // Ack may land in the same cycle the request rises
            if (fetch_ack && (fetch_pending || fetch_start)) begin
                fetch_pending     <= 1'b0;
                fetch_in_progress <= 1'b1;
            end
            if (row_loaded) begin
                fetch_in_progress <= 1'b0;
            end
        end
    end

    // Prefetch buffer occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (row_loaded) begin
            pfb_count <= cfg.num_cols;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Input position
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pos         <= '0;
            row_drained <= 1'b0;
        end else begin
            row_drained <= row_end;
            if (job_complete_ack) begin
                pos <= '0;
            end else if (row_end) begin
                pos.row <= pos.row + 1'b1;
                pos.col <= '0;
            end else if (pfb_rden) begin
                pos.col <= pos.col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pix_seq_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pix_seq_reader #(
    parameter int NUM_CE = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire qbc_pkg::job_cfg_t           cfg,
    input  wire                              pass_start,
    output logic                             seq_rden,
    output logic [qbc_pkg::SEQ_ADDR_W-1:0]   seq_addr,
    output logic [3:0]                       cycle_counter,
    output logic [NUM_CE-1:0]                ce_execute,
    output logic                             pass_done
);

    typedef logic [qbc_pkg::SEQ_ADDR_W-1:0] addr_t;

    localparam logic [3:0] LAST_CYCLE = 4'(qbc_pkg::WINDOW_CYCLES - 1);
    // Stages ahead of the first engine
    localparam int ALIGN_W = qbc_pkg::SEQ_RD_LATENCY - 1;

    addr_t              pass_reads;
    addr_t              reads_left;
    logic [ALIGN_W-1:0] rden_dly;
    logic               exec_tail_q;

    // Sequence entries per pass
    assign pass_reads = addr_t'(cfg.seq_windows) * addr_t'(qbc_pkg::WINDOW_CYCLES);

    assign seq_rden = (reads_left != '0);

    //////////////////////////////////////////////////
    // Sequence read side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            reads_left    <= '0;
            seq_addr      <= '0;
            cycle_counter <= '0;
        end else if (pass_start) begin
            reads_left    <= pass_reads;
            seq_addr      <= '0;
            cycle_counter <= '0;
        end else if (seq_rden) begin
            reads_left <= reads_left - 1'b1;
            seq_addr   <= seq_addr + 1'b1;
            // Wrap at the end of each window
            if (cycle_counter == LAST_CYCLE) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Latency alignment and execute chain
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly    <= '0;
            ce_execute  <= '0;
            exec_tail_q <= 1'b0;
            pass_done   <= 1'b0;
        end else begin
            rden_dly[0] <= seq_rden;
            for (int i = 1; i < ALIGN_W; i++) begin
                rden_dly[i] <= rden_dly[i-1];
            end

            // First engine sees data as it leaves the BRAM
            ce_execute[0] <= rden_dly[ALIGN_W-1];
            for (int k = 1; k < NUM_CE; k++) begin
                ce_execute[k] <= ce_execute[k-1];
            end

            // Falling edge at the end of the chain closes the pass
            exec_tail_q <= ce_execute[NUM_CE-1];
            pass_done   <= exec_tail_q && !ce_execute[NUM_CE-1];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/quad_bram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl #(
    parameter int NUM_CE = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire qbc_pkg::job_cfg_t           cfg,
    input  wire                              job_start,
    output logic                             job_accept,
    output logic                             fetch_request,
    input  wire                              fetch_ack,
    input  wire                              fetch_complete,
    output logic                             pfb_rden,
    output qbc_pkg::pos_t                    pos,
    output logic                             seq_rden,
    output logic [qbc_pkg::SEQ_ADDR_W-1:0]   seq_addr,
    output logic [3:0]                       cycle_counter,
    output logic [NUM_CE-1:0]                ce_execute,
    output logic [1:0]                       gray_code,
    input  wire                              pipeline_flushed,
    output logic                             job_complete,
    input  wire                              job_complete_ack
);

    // Sequencer to tracker and reader
    logic fetch_start;
    logic drain;
    logic row_loaded;
    logic row_drained;
    logic pass_start;
    logic pass_done;

    //////////////////////////////////////////////////
    // Job control
    //////////////////////////////////////////////////

    job_sequencer u_job_sequencer (
        .clk              (clk),
        .rst              (rst),
        .cfg              (cfg),
        .pos              (pos),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .fetch_request    (fetch_request),
        .fetch_ack        (fetch_ack),
        .row_loaded       (row_loaded),
        .row_drained      (row_drained),
        .fetch_start      (fetch_start),
        .drain            (drain),
        .pass_start       (pass_start),
        .pass_done        (pass_done),
        .pipeline_flushed (pipeline_flushed),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .gray_code        (gray_code),
        .state            ()
    );

    // Prefetch buffer side
    row_fetch_tracker u_row_fetch_tracker (
        .clk              (clk),
        .rst              (rst),
        .cfg              (cfg),
        .fetch_start      (fetch_start),
        .fetch_ack        (fetch_ack),
        .fetch_complete   (fetch_complete),
        .drain            (drain),
        .job_complete_ack (job_complete_ack),
        .pfb_rden         (pfb_rden),
        .row_loaded       (row_loaded),
        .row_drained      (row_drained),
        .pos              (pos)
    );

    // Pixel sequence and compute engines
    pix_seq_reader #(
        .NUM_CE (NUM_CE)
    ) u_pix_seq_reader (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .pass_start    (pass_start),
        .seq_rden      (seq_rden),
        .seq_addr      (seq_addr),
        .cycle_counter (cycle_counter),
        .ce_execute    (ce_execute),
        .pass_done     (pass_done)
    );

endmodule

`default_nettype wire

// ==== tests/quad_bram_ctrl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_props (
    input wire       clk,
    input wire       rst,
    input wire       job_accept,
    input wire       fetch_request,
    input wire       fetch_ack,
    input wire       job_complete,
    input wire       job_complete_ack,
    input wire [5:0] state
);

    //////////////////////////////////////////////////
    // Sequencer handshakes
    //////////////////////////////////////////////////

    a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept)
        else $error("job_accept high for more than one cycle");

    // Request drops once the ack has been seen
    a_request_falls: assert property (@(posedge clk) disable iff (rst)
        fetch_request && fetch_ack |=> !fetch_request)
        else $error("fetch_request still high after fetch_ack");

    a_state_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot(state))
        else $error("job state is not one-hot");

    a_complete_holds: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else $error("job_complete fell before job_complete_ack");

endmodule

bind job_sequencer quad_bram_ctrl_props u_props (
    .clk              (clk),
    .rst              (rst),
    .job_accept       (job_accept),
    .fetch_request    (fetch_request),
    .fetch_ack        (fetch_ack),
    .job_complete     (job_complete),
    .job_complete_ack (job_complete_ack),
    .state            (state)
);

`default_nettype wire

// ==== tests/quad_bram_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_tb;

    localparam int NUM_CE    = 4;
    localparam int MAX_JOBS  = 32;
    localparam int WINDOW    = 9;
    localparam int EXEC_DLY  = 3;
    localparam int HIST_LEN  = NUM_CE + EXEC_DLY;

    logic                            clk;
    logic                            rst;
    qbc_pkg::job_cfg_t               cfg;
    logic                            job_start;
    logic                            job_accept;
    logic                            fetch_request;
    logic                            fetch_ack;
    logic                            fetch_complete;
    logic                            pfb_rden;
    qbc_pkg::pos_t                   pos;
    logic                            seq_rden;
    logic [qbc_pkg::SEQ_ADDR_W-1:0]  seq_addr;
    logic [3:0]                      cycle_counter;
    logic [NUM_CE-1:0]               ce_execute;
    logic [1:0]                      gray_code;
    logic                            pipeline_flushed;
    logic                            job_complete;
    logic                            job_complete_ack;

    // Job table from the stimulus file
    int job_rows [MAX_JOBS];
    int job_cols [MAX_JOBS];
    int job_win [MAX_JOBS];
    int ack_dly [MAX_JOBS];
    int cpl_dly [MAX_JOBS];
    int flush_dly [MAX_JOBS];
    int cack_dly [MAX_JOBS];
    int exp_passes [MAX_JOBS];
    int exp_reads [MAX_JOBS];
    int num_jobs;

    int   seed;
    int   error_count;
    int   limit_cycles;
    logic limit_ready;
    logic mon_en;
    int   cur_ack_dly;
    int   cur_cpl_dly;

    // Running totals kept by the monitor and the fetch responder
    int accept_total;
    int complete_rises;
    int fetch_rises;
    int cpl_total;
    int pfb_total;
    int pass_total;

    // Monitor state
    logic prev_accept;
    logic prev_request;
    logic prev_complete;
    logic prev_pfb;
    logic prev_seq;
    int   pfb_run;
    int   seq_run;
    int   exp_row;
    int   exp_col;
    int   job_pass;
    logic hist [HIST_LEN];

    quad_bram_ctrl #(
        .NUM_CE (NUM_CE)
    ) dut (
        .clk              (clk),
        .rst              (rst),
        .cfg              (cfg),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .fetch_request    (fetch_request),
        .fetch_ack        (fetch_ack),
        .fetch_complete   (fetch_complete),
        .pfb_rden         (pfb_rden),
        .pos              (pos),
        .seq_rden         (seq_rden),
        .seq_addr         (seq_addr),
        .cycle_counter    (cycle_counter),
        .ce_execute       (ce_execute),
        .gray_code        (gray_code),
        .pipeline_flushed (pipeline_flushed),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reporting and reference helpers
    //////////////////////////////////////////////////

    task automatic stop_with_fail(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_fail($sformatf("ERROR: time %0d ns: %s: got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // Pass index 0,1,2,3 maps to 00,01,11,10
    function automatic logic [1:0] gray_of(input int passes);
        case (passes % 4)
            0:       gray_of = 2'b00;
            1:       gray_of = 2'b01;
            2:       gray_of = 2'b11;
            default: gray_of = 2'b10;
        endcase
    endfunction

    // Cycle budget of one job before doubling
    function automatic int job_budget(input int j);
        int per_row;
        int per_pass;
        per_row  = job_cols[j] + ack_dly[j] + cpl_dly[j] + 8;
        per_pass = job_win[j] * WINDOW + NUM_CE + 8;
        job_budget = job_rows[j] * per_row + (job_rows[j] - 2) * per_pass
                     + flush_dly[j] + cack_dly[j] + 8;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        int    f [9];
        fd = $fopen("tests/quad_bram_ctrl_stim.txt", "r");
        if (fd == 0) begin
            stop_with_fail("Could not open the stimulus file tests/quad_bram_ctrl_stim.txt");
        end
        num_jobs = 0;
        while (!$feof(fd) && num_jobs < MAX_JOBS) begin
            n = $fgets(line, fd);
            // Comment and blank lines do not parse as nine numbers
            if (n > 0 && $sscanf(line, "%d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                                 f[3], f[4], f[5], f[6], f[7], f[8]) == 9) begin
                job_rows[num_jobs]   = f[0];
                job_cols[num_jobs]   = f[1];
                job_win[num_jobs]    = f[2];
                ack_dly[num_jobs]    = f[3];
                cpl_dly[num_jobs]    = f[4];
                flush_dly[num_jobs]  = f[5];
                cack_dly[num_jobs]   = f[6];
                exp_passes[num_jobs] = f[7];
                exp_reads[num_jobs]  = f[8];
                num_jobs++;
            end
        end
        $fclose(fd);
        if (num_jobs == 0) begin
            stop_with_fail("The stimulus file holds no jobs");
        end
    endtask

    //////////////////////////////////////////////////
    // One job from start to acknowledged completion
    //////////////////////////////////////////////////

    task automatic run_job(input int j);
        int gap;
        int acc0;
        int cpl0;
        int fet0;
        int pfb0;
        int pass0;
        gap = $unsigned($random(seed)) % 5;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        acc0  = accept_total;
        cpl0  = complete_rises;
        fet0  = fetch_rises;
        pfb0  = pfb_total;
        pass0 = pass_total;

        @(negedge clk);
        cfg.num_rows    = job_rows[j];
        cfg.num_cols    = job_cols[j];
        cfg.seq_windows = job_win[j];
        cur_ack_dly     = ack_dly[j];
        cur_cpl_dly     = cpl_dly[j];
        job_start       = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        check(job_accept, 1'b1, "job_accept in the cycle after job_start");

        // Flush once the last pass has left the engine chain
        do @(posedge clk); while (pass_total - pass0 < exp_passes[j]);
        @(negedge clk);
        while (ce_execute != '0) @(negedge clk);
        repeat (flush_dly[j]) begin
            @(negedge clk);
            check(job_complete, 1'b0, "job_complete before pipeline_flushed");
        end
        pipeline_flushed = 1'b1;

        while (!job_complete) @(negedge clk);
        repeat (cack_dly[j]) begin
            @(negedge clk);
            check(job_complete, 1'b1, "job_complete held until job_complete_ack");
        end
        job_complete_ack = 1'b1;
        @(negedge clk);
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        check(job_complete, 1'b0, "job_complete after job_complete_ack");
        check(pos, '0, "pos after job completion");
        check(gray_code, 2'b00, "gray_code after job completion");

        @(posedge clk);
        check(accept_total - acc0, 1, "job_accept pulses per job");
        check(complete_rises - cpl0, 1, "job_complete rises per job");
        check(fetch_rises - fet0, job_rows[j], "fetch_request rises per job");
        check(pfb_total - pfb0, exp_reads[j], "pfb_rden cycles per job");
        check(pass_total - pass0, exp_passes[j], "passes per job");
    endtask

    //////////////////////////////////////////////////
    // Prefetch buffer responder
    //////////////////////////////////////////////////

    initial begin : fetch_responder
        wait (mon_en);
        forever begin
            @(negedge clk);
            if (fetch_request) begin
                repeat (cur_ack_dly) begin
                    @(negedge clk);
                    check(fetch_request, 1'b1, "fetch_request held until fetch_ack");
                end
                fetch_ack = 1'b1;
                @(negedge clk);
                fetch_ack = 1'b0;
                repeat (cur_cpl_dly) @(negedge clk);
                fetch_complete = 1'b1;
                @(posedge clk);
                cpl_total++;
                @(negedge clk);
                fetch_complete = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        int k;
        if (mon_en) begin
            if (job_accept) begin
                check(prev_accept, 1'b0, "job_accept wider than one cycle");
                accept_total++;
            end
            if (job_complete && !prev_complete) begin
                complete_rises++;
                check(gray_code, gray_of(job_pass), "gray_code at job_complete");
                check(exp_row, cfg.num_rows, "rows drained before job_complete");
            end
            if (!job_complete && prev_complete) begin
                exp_row  = 0;
                exp_col  = 0;
                job_pass = 0;
            end
            if (fetch_request && !prev_request) begin
                check(fetch_rises, cpl_total, "fetch_request raised before fetch_complete");
                fetch_rises++;
            end

            // Prefetch buffer drain and input position
            if (pfb_rden) begin
                if (!prev_pfb) begin
                    check(cpl_total, fetch_rises, "pfb_rden before fetch_complete");
                end
                check(pos.row, exp_row, "pos.row during drain");
                check(pos.col, exp_col, "pos.col during drain");
                pfb_run++;
                pfb_total++;
                if (exp_col == cfg.num_cols - 1) begin
                    exp_row++;
                    exp_col = 0;
                end else begin
                    exp_col++;
                end
            end else if (prev_pfb) begin
                check(pfb_run, cfg.num_cols, "pfb_rden run length");
                pfb_run = 0;
            end

            // Sequence reads of one pass
            if (seq_rden) begin
                if (!prev_seq) begin
                    check(gray_code, gray_of(job_pass), "gray_code at pass start");
                end
                check(seq_addr, seq_run, "seq_addr");
                check(cycle_counter, seq_run % WINDOW, "cycle_counter");
                seq_run++;
            end else if (prev_seq) begin
                check(seq_run, cfg.seq_windows * WINDOW, "seq_rden run length");
                seq_run = 0;
                job_pass++;
                pass_total++;
            end

            // hist[d] is seq_rden d+1 cycles back
            for (k = 0; k < NUM_CE; k++) begin
                check(ce_execute[k], hist[EXEC_DLY - 1 + k],
                      $sformatf("ce_execute[%0d] delay from seq_rden", k));
            end
            for (k = HIST_LEN - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = seq_rden;

            prev_accept   = job_accept;
            prev_request  = fetch_request;
            prev_complete = job_complete;
            prev_pfb      = pfb_rden;
            prev_seq      = seq_rden;
        end
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial begin : watchdog
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk);
        stop_with_fail($sformatf("Timeout: the jobs did not finish within %0d clock cycles",
                                 limit_cycles));
    end

    initial begin : main_flow
        int j;
        seed             = 79;
        error_count      = 0;
        limit_ready      = 1'b0;
        mon_en           = 1'b0;
        rst              = 1'b1;
        cfg              = '0;
        job_start        = 1'b0;
        fetch_ack        = 1'b0;
        fetch_complete   = 1'b0;
        pipeline_flushed = 1'b0;
        job_complete_ack = 1'b0;
        cur_ack_dly      = 0;
        cur_cpl_dly      = 0;
        accept_total     = 0;
        complete_rises   = 0;
        fetch_rises      = 0;
        cpl_total        = 0;
        pfb_total        = 0;
        pass_total       = 0;
        prev_accept      = 1'b0;
        prev_request     = 1'b0;
        prev_complete    = 1'b0;
        prev_pfb         = 1'b0;
        prev_seq         = 1'b0;
        pfb_run          = 0;
        seq_run          = 0;
        exp_row          = 0;
        exp_col          = 0;
        job_pass         = 0;
        for (j = 0; j < HIST_LEN; j++) begin
            hist[j] = 1'b0;
        end

        load_stimulus();
        limit_cycles = 64;
        for (j = 0; j < num_jobs; j++) begin
            limit_cycles += job_budget(j);
        end
        limit_cycles = limit_cycles * 2;
        limit_ready  = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Nothing active out of reset
        check(job_accept, 1'b0, "job_accept after reset");
        check(fetch_request, 1'b0, "fetch_request after reset");
        check(pfb_rden, 1'b0, "pfb_rden after reset");
        check(seq_rden, 1'b0, "seq_rden after reset");
        check(ce_execute, '0, "ce_execute after reset");
        check(job_complete, 1'b0, "job_complete after reset");
        check(gray_code, 2'b00, "gray_code after reset");
        check(pos, '0, "pos after reset");
        @(posedge clk);
        mon_en = 1'b1;

        for (j = 0; j < num_jobs; j++) begin
            run_job(j);
        end

        @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_fail("Checks reported errors");
        end
    end

endmodule

`default_nettype wire

// ==== tests/quad_bram_ctrl_stim.txt ====
// num_rows num_cols seq_windows fetch_ack_dly fetch_cpl_dly flush_dly cpl_ack_dly
// exp_passes exp_pfb_reads (decimal, one job per line)
3 4 2 0 0 0 0 1 12
4 5 1 1 2 3 1 2 20
7 3 2 0 1 0 2 5 21
5 8 3 2 0 1 0 3 40
3 1 1 3 3 2 3 1 3
6 6 2 1 1 4 1 4 36
8 2 1 0 0 0 0 6 16
4 10 4 2 3 1 2 2 40
9 4 1 1 0 2 1 7 36
10 3 2 0 2 0 0 8 30

// ==== compile.f ====
hdl/qbc_pkg.sv
hdl/job_sequencer.sv
hdl/row_fetch_tracker.sv
hdl/pix_seq_reader.sv
hdl/quad_bram_ctrl.sv
tests/quad_bram_ctrl_props.sv
tests/quad_bram_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: quad_bram_ctrl

sources:
  # RTL in compile order
  - hdl/qbc_pkg.sv
  - hdl/job_sequencer.sv
  - hdl/row_fetch_tracker.sv
  - hdl/pix_seq_reader.sv
  - hdl/quad_bram_ctrl.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/quad_bram_ctrl_props.sv
      - tests/quad_bram_ctrl_tb.sv
